//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // field widths of the base encoding
    localparam int XLEN       = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes, only the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        BRANCH = 7'b1100011,
        OP_IMM = 7'b0010011
    } opcode_t;

    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000; // sub

endpackage

//--- hdl/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

    // operation code seen by the ALU
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7
    } alu_ctrl_t;

    // immediate format picked by the decoder
    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2
    } imm_sel_t;

    // class handed from main decoder to the ALU decoder
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'd0,
        ALUOP_SUB   = 2'd1,
        ALUOP_FUNCT = 2'd2
    } alu_op_t;

endpackage

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_ctrl_t op,
    output word_t     result,
    output logic      zero
);
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_SLL:  result = a << b[4:0]; // shamt only
            default:  result = a + b;
        endcase
    end

    // used by the branch compare
    assign zero = (result == '0);

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
    input  word_t    instr,
    input  imm_sel_t sel,
    output word_t    imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (sel)
            IMM_S:   imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                // offset in halfwords, bit 0 always zero
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: imm = {{20{sign}}, instr[31:20]}; // I format
        endcase
    end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      we,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);
    localparam int NREGS = 2 ** REG_ADDR_W;

    word_t regs [NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata; // x0 never written
        end
    end

    // x0 reads zero even before the first reset
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/instr_mem.sv
`timescale 1ns/1ns

module instr_mem
    import rv_isa_pkg::*;
#(
    parameter int IMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  we,
    input  word_t waddr,
    input  word_t wdata,
    input  word_t addr,
    output word_t instr
);
    localparam int AW = $clog2(IMEM_DEPTH);

    word_t mem [IMEM_DEPTH];

    // loaded through the program port only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW+1:2]] <= wdata;
        end
    end

    // byte address in, high bits dropped so fetch wraps
    assign instr = mem[addr[AW+1:2]];

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/1ns

module data_mem
    import rv_isa_pkg::*;
#(
    parameter int DMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  we,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata
);
    localparam int AW = $clog2(DMEM_DEPTH);

    word_t           mem [DMEM_DEPTH];
    logic [AW-1:0]   idx;

    // word index, wraps modulo depth
    assign idx = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx]; // same cycle as the load

endmodule

//--- hdl/controller.sv
`timescale 1ns/1ns

module controller
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
(
    input  opcode_t               opcode,
    input  logic [FUNCT3_W-1:0]   funct3,
    input  logic [FUNCT7_W-1:0]   funct7,
    input  logic                  alu_zero,
    output logic                  alu_src,
    output logic                  result_src,
    output logic                  pc_src,
    output logic                  memwrite,
    output logic                  regwrite,
    output alu_ctrl_t             alu_control,
    output imm_sel_t              imm_sel
);
    alu_op_t alu_op;
    logic    branch;

    // main decoder
    always_comb begin
        alu_src    = 1'b0;
        result_src = 1'b0;
        memwrite   = 1'b0;
        regwrite   = 1'b0;
        branch     = 1'b0;
        imm_sel    = IMM_I;
        alu_op     = ALUOP_ADD;
        case (opcode)
            LOAD: begin
                regwrite   = 1'b1;
                alu_src    = 1'b1;
                result_src = 1'b1; // write back from memory
            end
            STORE: begin
                imm_sel  = IMM_S;
                alu_src  = 1'b1;
                memwrite = 1'b1;
            end
            OP: begin
                regwrite = 1'b1;
                alu_op   = ALUOP_FUNCT;
            end
            BRANCH: begin
                // compare by subtraction, funct3 not looked at
                imm_sel = IMM_B;
                alu_op  = ALUOP_SUB;
                branch  = 1'b1;
            end
            OP_IMM: begin
                regwrite = 1'b1;
                alu_src  = 1'b1;
                alu_op   = ALUOP_FUNCT;
            end
            default: begin
                // unknown opcode behaves as a bubble
            end
        endcase
    end

    assign pc_src = branch & alu_zero;

    // ALU decoder, order matters
    // funct7 is checked for I-type too, so an immediate of 0x400-ish picks sub
    always_comb begin
        if (alu_op == ALUOP_ADD) begin
            alu_control = ALU_ADD;
        end else if (alu_op == ALUOP_SUB) begin
            alu_control = ALU_SUB;
        end else if (funct3 == F3_ADD && funct7 == FUNCT7_ALT) begin
            alu_control = ALU_SUB;
        end else if (funct3 == F3_ADD && funct7 == FUNCT7_BASE) begin
            alu_control = ALU_ADD;
        end else begin
            case (funct3)
                F3_SLT:  alu_control = ALU_SLT;
                F3_OR:   alu_control = ALU_OR;
                F3_AND:  alu_control = ALU_AND;
                F3_XOR:  alu_control = ALU_XOR;
                F3_SLTU: alu_control = ALU_SLTU;
                F3_SLL:  alu_control = ALU_SLL;
                default: alu_control = ALU_ADD; // 101 and odd funct7 land here
            endcase
        end
    end

endmodule

//--- hdl/rv_core.sv
`timescale 1ns/1ns

module rv_core
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
#(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  prog_we,
    input  word_t prog_addr,
    input  word_t prog_data,
    output word_t pc,
    output logic  store_en,
    output word_t store_addr,
    output word_t store_data
);
    word_t     instr;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_b;
    word_t     alu_result;
    word_t     mem_rdata;
    word_t     wb_data;
    word_t     pc_plus4;
    word_t     pc_target;
    word_t     pc_next;
    logic      alu_zero;
    logic      alu_src;
    logic      result_src;
    logic      pc_src;
    logic      memwrite;
    logic      regwrite;
    logic      reg_we;
    alu_ctrl_t alu_control;
    imm_sel_t  imm_sel;

    // program counter
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm; // imm is the B offset on branches
    assign pc_next   = pc_src ? pc_target : pc_plus4;

    instr_mem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) instr_mem_i (
        .clk   (clk),
        .we    (prog_we & rst), // loading only while held in reset
        .waddr (prog_addr),
        .wdata (prog_data),
        .addr  (pc),
        .instr (instr)
    );

    controller controller_i (
        .opcode      (opcode_t'(instr[6:0])),
        .funct3      (instr[14:12]),
        .funct7      (instr[31:25]),
        .alu_zero    (alu_zero),
        .alu_src     (alu_src),
        .result_src  (result_src),
        .pc_src      (pc_src),
        .memwrite    (memwrite),
        .regwrite    (regwrite),
        .alu_control (alu_control),
        .imm_sel     (imm_sel)
    );

    imm_gen imm_gen_i (
        .instr (instr),
        .sel   (imm_sel),
        .imm   (imm)
    );

    assign reg_we = regwrite & ~rst;

    reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .rs1    (instr[19:15]),
        .rs2    (instr[24:20]),
        .rd     (instr[11:7]),
        .we     (reg_we),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = alu_src ? imm : rdata2;

    alu alu_i (
        .a      (rdata1),
        .b      (alu_b),
        .op     (alu_control),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // store port mirrors the data memory write side
    assign store_en   = memwrite & ~rst;
    assign store_addr = alu_result;
    assign store_data = rdata2;

    data_mem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) data_mem_i (
        .clk   (clk),
        .we    (store_en),
        .addr  (alu_result),
        .wdata (rdata2),
        .rdata (mem_rdata)
    );

    assign wb_data = result_src ? mem_rdata : alu_result;

endmodule

//--- test/rv_core_sva.sv
`timescale 1ns/1ns

module rv_core_sva
    import rv_isa_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input word_t pc,
    input logic  store_en
);
    int fail_count = 0; // read by the testbench at the end

    no_store_in_reset: assert property (@(posedge clk) rst |-> !store_en)
        else begin
            $error("store_en high while rst is high");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned");
            fail_count++;
        end

    // first cycle out of reset fetches from 0
    pc_zero_after_reset: assert property (@(posedge clk) $fell(rst) |-> pc == '0)
        else begin
            $error("pc not 0 in the first cycle after reset");
            fail_count++;
        end

endmodule

bind rv_core rv_core_sva rv_core_sva_i (
    .clk      (clk),
    .rst      (rst),
    .pc       (pc),
    .store_en (store_en)
);

//--- test/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

word_t model_regs [32];
word_t model_mem  [DMEM_DEPTH]; // kept across resets, like the data memory
word_t model_pc;

function automatic word_t model_alu(logic [2:0] f3, logic [6:0] f7, word_t a, word_t b);
    alu_ctrl_t op;
    case (f3)
        3'b000:  op = (f7 == 7'b0100000) ? ALU_SUB : ALU_ADD; // I-type included
        3'b001:  op = ALU_SLL;
        3'b010:  op = ALU_SLT;
        3'b011:  op = ALU_SLTU;
        3'b100:  op = ALU_XOR;
        3'b110:  op = ALU_OR;
        3'b111:  op = ALU_AND;
        default: op = ALU_ADD; // 101, no shift right
    endcase
    case (op)
        ALU_SUB:  return a - b;
        ALU_SLL:  return a << b[4:0];
        ALU_SLT:  return word_t'($signed(a) < $signed(b));
        ALU_SLTU: return word_t'(a < b);
        ALU_XOR:  return a ^ b;
        ALU_OR:   return a | b;
        ALU_AND:  return a & b;
        default:  return a + b;
    endcase
endfunction

task automatic model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_pc = '0;
endtask

// executes one instruction, returns the store it makes and moves model_pc
task automatic step_model(input word_t instr, output logic st_en, output word_t st_addr,
                          output word_t st_data);
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm_i;
    word_t     imm_s;
    word_t     imm_b;
    word_t     next_pc;
    word_t     result;
    reg_addr_t rd;
    rs1_val = model_regs[instr[19:15]];
    rs2_val = model_regs[instr[24:20]];
    rd      = instr[11:7];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    next_pc = model_pc + 4;
    st_en   = 1'b0;
    st_addr = '0;
    st_data = '0;
    result  = '0;
    case (opcode_t'(instr[6:0]))
        LOAD:   result = model_mem[((rs1_val + imm_i) >> 2) % DMEM_DEPTH];
        OP:     result = model_alu(instr[14:12], instr[31:25], rs1_val, rs2_val);
        OP_IMM: result = model_alu(instr[14:12], instr[31:25], rs1_val, imm_i);
        STORE: begin
            st_en   = 1'b1;
            st_addr = rs1_val + imm_s;
            st_data = rs2_val;
            model_mem[(st_addr >> 2) % DMEM_DEPTH] = rs2_val;
        end
        BRANCH: begin
            if (rs1_val == rs2_val) begin
                next_pc = model_pc + imm_b; // beq for every funct3
            end
        end
        default: begin
        end
    endcase
    if (rd != 0 && (instr[6:0] == LOAD || instr[6:0] == OP || instr[6:0] == OP_IMM)) begin
        model_regs[rd] = result;
    end
    model_pc = next_pc;
endtask

`endif

//--- test/rv_core_tb.sv
`timescale 1ns/1ns

module rv_core_tb
    import rv_isa_pkg::*, rv_ctrl_pkg::*;
();
    localparam int PERIOD       = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int PROG_LEN     = 16;  // one word per reset cycle
    localparam int FILL_CYCLES  = 270; // fill loop ends after 257
    localparam int RAND_ROUNDS  = 16;
    localparam int RUN_CYCLES   = 25;  // 400 random cycles in all
    localparam int TOTAL_CYCLES = (RAND_ROUNDS + 1) * (PROG_LEN + 2) + FILL_CYCLES
                                  + RAND_ROUNDS * RUN_CYCLES;

    logic        clk;
    logic        rst;
    logic        prog_we;
    word_t       prog_addr;
    word_t       prog_data;
    word_t       pc;
    logic        store_en;
    word_t       store_addr;
    word_t       store_data;
    word_t       prog_words [PROG_LEN];
    logic        in_reset;
    logic        running;
    logic        exp_en;
    word_t       exp_addr;
    word_t       exp_data;
    int unsigned lcg_state = 4;

    `include "rv_model.svh"

    rv_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) rv_core_i (
        .clk        (clk),
        .rst        (rst),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc         (pc),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pc(input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("FAILED pc: got %h, expected %h", act, exp);
            abort_run();
        end
    endtask

    task automatic check_store(input logic act_en, input word_t act_addr, input word_t act_data,
                               input logic en, input word_t addr, input word_t data);
        if (act_en !== en) begin
            $display("FAILED store_en: got %h, expected %h", act_en, en);
            abort_run();
        end
        if (en && act_addr !== addr) begin
            $display("FAILED store_addr: got %h, expected %h", act_addr, addr);
            abort_run();
        end
        if (en && act_data !== data) begin
            $display("FAILED store_data: got %h, expected %h", act_data, data);
            abort_run();
        end
    endtask

    function automatic int unsigned lcg_next(input int unsigned bound);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % bound;
    endfunction

    // R-type goes through here too, upper = {funct7, rs2}
    function automatic word_t encode_i(opcode_t op, logic [2:0] f3, reg_addr_t rd,
                                       reg_addr_t rs1, logic [11:0] upper);
        return {upper, rs1, f3, rd, op};
    endfunction

    function automatic word_t encode_s(reg_addr_t rs1, reg_addr_t rs2, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t encode_b(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                       logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    // writes every data word with its own address
    task automatic build_fill_program();
        prog_words[0] = encode_i(OP_IMM, 3'b000, 5'd1, 5'd0, 12'd0);
        prog_words[1] = encode_i(OP_IMM, 3'b000, 5'd2, 5'd0, 12'(DMEM_DEPTH * 4));
        prog_words[2] = encode_s(5'd1, 5'd1, 12'd0);
        prog_words[3] = encode_i(OP_IMM, 3'b000, 5'd1, 5'd1, 12'd4);
        prog_words[4] = encode_b(3'b000, 5'd1, 5'd2, 13'd8);  // done, skip back jump
        prog_words[5] = encode_b(3'b000, 5'd0, 5'd0, 13'(-12));
        for (int i = 6; i < PROG_LEN; i++) begin
            prog_words[i] = encode_b(3'b000, 5'd0, 5'd0, 13'd0);
        end
    endtask

    task automatic build_random_program();
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        prog_words[0] = encode_i(OP_IMM, 3'b000, 5'(1 + lcg_next(7)), 5'd0, 12'(lcg_next(64)));
        for (int i = 1; i < PROG_LEN - 1; i++) begin
            rd  = 5'(lcg_next(8)); // x0 included on purpose
            rs1 = 5'(lcg_next(8));
            rs2 = 5'(lcg_next(8));
            f3  = 3'(lcg_next(8));
            imm = 12'(4 * lcg_next(DMEM_DEPTH));
            case (lcg_next(10))
                0, 1: prog_words[i] = encode_i(LOAD, 3'b010, rd, 5'd0, imm);
                2, 3: prog_words[i] = encode_s(5'd0, rs2, imm);
                4, 5: prog_words[i] = encode_i(OP, f3, rd, rs1,
                                               {lcg_next(2) ? FUNCT7_ALT : 7'd0, rs2});
                6, 7: begin
                    imm = 12'(int'(lcg_next(64)) - 32);
                    if (lcg_next(3) == 0) begin
                        f3  = 3'b000;
                        imm = {FUNCT7_ALT, 5'(lcg_next(32))}; // addi that subtracts
                    end
                    prog_words[i] = encode_i(OP_IMM, f3, rd, rs1, imm);
                end
                default: begin
                    if (lcg_next(2) != 0) begin
                        rs2 = rs1;
                    end
                    prog_words[i] = encode_b(f3, rs1, rs2,
                                             13'((int'(lcg_next(PROG_LEN)) - i) * 4));
                end
            endcase
        end
        prog_words[PROG_LEN - 1] = encode_b(3'b000, 5'd0, 5'd0, 13'd0);
    endtask

    // program written while rst is held
    task automatic load_program(input logic fill);
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (i == 0) begin
                // old words are still needed by the last check before this
                if (fill) begin
                    build_fill_program();
                end else begin
                    build_random_program();
                end
            end
            running   = 1'b0;
            rst       = 1'b1;
            in_reset  = (i != 0);
            prog_we   = 1'b1;
            prog_addr = word_t'(i * 4);
            prog_data = prog_words[i];
        end
        @(posedge clk);
        #DRIVE_DLY;
        rst      = 1'b0;
        prog_we  = 1'b0;
        in_reset = 1'b0;
        model_reset();
        running  = 1'b1;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            check_store(store_en, store_addr, store_data, 1'b0, '0, '0);
        end
        if (in_reset) begin
            check_pc(pc, '0);
        end else if (running) begin
            check_pc(pc, model_pc);
            step_model(prog_words[(model_pc >> 2) % PROG_LEN], exp_en, exp_addr, exp_data);
            check_store(store_en, store_addr, store_data, exp_en, exp_addr, exp_data);
        end
    end

    initial begin
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        in_reset  = 1'b0;
        running   = 1'b0;
        for (int r = 0; r <= RAND_ROUNDS; r++) begin
            load_program(r == 0);
            repeat (r == 0 ? FILL_CYCLES : RUN_CYCLES) @(posedge clk);
        end
        if (rv_core_i.rv_core_sva_i.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("core assertions failed %0d times", rv_core_i.rv_core_sva_i.fail_count);
            abort_run();
        end
    end

    initial begin
        #((TOTAL_CYCLES + 20) * PERIOD);
        $display("timeout, the run did not finish in %0d cycles", TOTAL_CYCLES + 20);
        abort_run();
    end

endmodule

//--- files.f
+incdir+test
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/alu.sv
hdl/imm_gen.sv
hdl/reg_file.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/controller.sv
hdl/rv_core.sv
test/rv_core_sva.sv
test/rv_core_tb.sv
